// ==== conv1_engine.f ====
+incdir+verilog
verilog/conv1_pkg.sv
verilog/ifmap_shift_register.sv
verilog/conv1_pe.sv
verilog/conv1_weight_regs.sv
verilog/conv1_input_fifo.sv
verilog/conv1_flow_ctrl.sv
verilog/conv1_engine.sv
verification/conv1_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the conv1 engine testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module conv1_engine_tb -f conv1_engine.f \
  -Mdir obj_dir -o conv1_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/conv1_sim > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// ==== verification/conv1_engine_tb.sv ====
`timescale 1ns/1ps
`include "conv1_defines.svh"

module conv1_engine_tb import conv1_pkg::*; ();

  localparam int    FIFO_DEPTH = `CONV1_IN_FIFO_DEPTH;   // sender credits at reset
  localparam int    GRANT_MAX  = `CONV1_OUT_CREDIT_MAX;  // receiver grant limit
  localparam string DATA_FILE  = "verification/conv1_testdata.txt";

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  column_t   in_column;
  logic      in_credit;
  logic      out_credit;
  logic      out_valid;
  psum_t     out_psum;
  logic      cfg_we;
  cfg_addr_t cfg_addr;
  psum_t     cfg_wdata;

  logic [7:0]  cmd_tag [$];   // C, I or E per data line
  logic [23:0] cmd_val [$];   // address, column or expected psum
  psum_t       cmd_data [$];  // config value, C lines only
  column_t     stage_in [$];  // columns of the next stream
  psum_t       stage_exp [$];
  column_t     send_q [$];    // columns the sender still has to send
  psum_t       exp_q [$];     // results still owed by the DUT

  credit_cnt_t send_credits  = credit_cnt_t'(FIFO_DEPTH);
  credit_cnt_t grants_out    = '0;  // grants not yet answered by a result
  int          credit_pulses = 0;
  int          beats_sent    = 0;
  int          beats_total   = 0;   // I lines in the file
  int          results_total = 0;
  int          cycle_cnt     = 0;
  int          cycle_limit   = 1000;

  conv1_engine dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_column  (in_column),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_psum   (out_psum),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata)
  );

  always #50 clk = ~clk;  // 100 ns period

  task automatic stop_run();
    $display("test failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic report_mismatch(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic report_fault(input string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_psum(input psum_t got, input psum_t exp, input int idx);
    if (got !== exp)
      report_mismatch($sformatf("result %0d is %0d, expected %0d", idx, got, exp));
  endtask

  task automatic check_count(input credit_cnt_t got, input credit_cnt_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic load_testdata();
    int          fd;
    int          ch;
    logic [7:0]  c;
    logic [23:0] a;
    logic [19:0] b;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) report_fault("cannot open the test data file");
    ch = $fgetc(fd);
    while (ch != -1) begin
      c = ch[7:0];
      if (c == "#") begin  // comment runs to end of line
        while (ch != -1 && ch[7:0] != "\n") ch = $fgetc(fd);
      end else if (c == "C") begin
        if ($fscanf(fd, "%h %h", a, b) != 2) report_fault("bad config line in test data");
        cmd_tag.push_back(c);
        cmd_val.push_back(a);
        cmd_data.push_back(psum_t'(b));
      end else if (c == "I" || c == "E") begin
        if ($fscanf(fd, "%h", a) != 1) report_fault("bad stream line in test data");
        cmd_tag.push_back(c);
        cmd_val.push_back(a);
        cmd_data.push_back('0);
        if (c == "I") beats_total++;
      end else if (c > " ") begin
        report_fault("unknown tag in test data");
      end
      ch = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  task automatic write_cfg(input cfg_addr_t addr, input psum_t data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  // hand staged beats to the credit models and wait for the stream to drain
  task automatic run_stream();
    @(posedge clk);
    while (stage_in.size() != 0) send_q.push_back(stage_in.pop_front());
    while (stage_exp.size() != 0) exp_q.push_back(stage_exp.pop_front());
    while (send_q.size() != 0 || exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);  // last in_credit lands
    if (credit_pulses != beats_sent)
      report_mismatch($sformatf("%0d in_credit pulses for %0d beats consumed",
                                credit_pulses, beats_sent));
    check_count(dut0.u_flow.credit_cnt, grants_out, "output credits held by the DUT");
  endtask

  // credit models, sampled and driven on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (in_credit) begin
        if (send_credits == credit_cnt_t'(FIFO_DEPTH))
          report_fault("in_credit returned with no beat in flight");
        send_credits = send_credits + 1'b1;
        credit_pulses++;
      end
      if (out_valid) begin
        if (grants_out == '0) begin
          report_fault("out_valid raised without an output credit");
        end else if (exp_q.size() == 0) begin
          report_fault("out_valid raised with no result left to expect");
        end else begin
          check_psum(out_psum, exp_q.pop_front(), results_total);
          grants_out = grants_out - 1'b1;
          results_total++;
        end
      end
      if (send_q.size() != 0 && send_credits != '0 && ($urandom % 4) != 0) begin
        in_valid     = 1'b1;  // one beat per credit
        in_column    = send_q.pop_front();
        send_credits = send_credits - 1'b1;
        beats_sent++;
      end else begin
        in_valid = 1'b0;
      end
      if (grants_out < credit_cnt_t'(GRANT_MAX) && exp_q.size() > int'(grants_out)
          && ($urandom % 3) != 0) begin
        out_credit = 1'b1;  // grant only what is still owed
        grants_out = grants_out + 1'b1;
      end else begin
        out_credit = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("simulation hung waiting for results after %0d cycles", cycle_cnt);
      stop_run();
    end
  end

  initial begin
    void'($urandom(32'hf6c5_e8d6));
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_column  = '0;
    out_credit = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    load_testdata();
    cycle_limit = 40 * beats_total + 200;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (10) begin  // idle engine stays quiet
      @(negedge clk);
      if (in_credit || out_valid) report_fault("in_credit or out_valid raised while idle");
    end
    for (int i = 0; i < cmd_tag.size(); i++) begin
      if (cmd_tag[i] == "C") begin
        if (stage_in.size() != 0 || stage_exp.size() != 0) run_stream();  // drain first
        write_cfg(cmd_val[i][3:0], cmd_data[i]);
      end else if (cmd_tag[i] == "I") begin
        stage_in.push_back(cmd_val[i]);
      end else begin
        stage_exp.push_back(psum_t'(cmd_val[i][19:0]));
      end
    end
    if (stage_in.size() != 0 || stage_exp.size() != 0) run_stream();
    repeat (20) @(negedge clk);  // stray results would show here
    if (results_total != beats_total - `CONV1_FILL_BEATS) begin
      report_mismatch($sformatf("%0d results for %0d input beats",
                                results_total, beats_total));
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// ==== verification/conv1_testdata.txt ====
# C addr data = config write (0..8 weight row*3+tap, 9 bias) | I column {row2,row1,row0}
# E expected out_psum, 20-bit two's complement, in output order; all values hex
C 0 01
C 1 fe
C 2 03
C 3 ff
C 4 04
C 5 02
C 6 02
C 7 fd
C 8 01
C 9 fff9c
I 1e140a
I 3c0528
I 080fc8
I 0cfa07
I ff215a
I 408003
I 014632
I b40264
E fffd9
E ffe13
E 00807
E ffe87
C 0 fc
C 1 02
C 3 05
C 4 ff
C 6 fe
C 7 06
C 8 fb
C 9 003e8
I 091019
I 4dff00
I 1e2878
I 21160b
I 6406f0
I 2d5a3c
E fff55
E ffdc7
E 009dd
E 0064d
E 003a1
E 005e1

// ==== verilog/conv1_defines.svh ====
`ifndef CONV1_DEFINES_SVH
`define CONV1_DEFINES_SVH

// datapath widths
`define CONV1_PIX_W          8   // unsigned pixel
`define CONV1_WGT_W          8   // signed weight
`define CONV1_PSUM_W         20  // partial sum and final result

// window geometry
`define CONV1_TAPS           3   // window width, taps per PE
`define CONV1_NUM_PE         3   // window height, PEs in the chain

// stream flow control
`define CONV1_IN_FIFO_DEPTH  4   // input credits held by sender after reset
`define CONV1_OUT_CREDIT_MAX 4   // most output grants outstanding

// pipeline fill, beats accepted before first valid result
`define CONV1_FILL_BEATS     4

`endif

// ==== verilog/conv1_engine.sv ====
`timescale 1ns/1ps

module conv1_engine import conv1_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // column stream in, credit based
  input  logic      in_valid,
  input  column_t   in_column,
  output logic      in_credit,
  // result stream out, credit based
  input  logic      out_credit,
  output logic      out_valid,
  output psum_t     out_psum,
  // config port
  input  logic      cfg_we,
  input  cfg_addr_t cfg_addr,
  input  psum_t     cfg_wdata
);

  column_t     fifo_column;  // head beat, row k to PE k
  logic        fifo_empty;
  logic        beat_en;      // one accepted beat
  weight_row_t weight_row0;
  weight_row_t weight_row1;
  weight_row_t weight_row2;
  psum_t       bias;         // seeds the psum chain
  psum_t       psum0;        // row 0 sum
  psum_t       psum1;        // rows 0..1 sum

  conv1_input_fifo u_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_column   (in_column),
    .pop         (beat_en),
    .fifo_column (fifo_column),
    .fifo_empty  (fifo_empty),
    .in_credit   (in_credit)
  );

  conv1_flow_ctrl u_flow (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_empty (fifo_empty),
    .out_credit (out_credit),
    .beat_en    (beat_en),
    .out_valid  (out_valid)
  );

  conv1_weight_regs u_wregs (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .weight_row0 (weight_row0),
    .weight_row1 (weight_row1),
    .weight_row2 (weight_row2),
    .bias        (bias)
  );

  // top row, no skew, adds bias
  conv1_pe #(.SKEW(0)) u_pe0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .beat_en    (beat_en),
    .pixel_in   (fifo_column[0 +: $bits(pixel_t)]),
    .weight_row (weight_row0),
    .psum_in    (bias),
    .psum_out   (psum0)
  );

  conv1_pe #(.SKEW(1)) u_pe1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .beat_en    (beat_en),
    .pixel_in   (fifo_column[$bits(pixel_t) +: $bits(pixel_t)]),
    .weight_row (weight_row1),
    .psum_in    (psum0),
    .psum_out   (psum1)
  );

  // last row, its psum is the engine result
  conv1_pe #(.SKEW(2)) u_pe2 (
    .clk        (clk),
    .rst_n      (rst_n),
    .beat_en    (beat_en),
    .pixel_in   (fifo_column[2*$bits(pixel_t) +: $bits(pixel_t)]),
    .weight_row (weight_row2),
    .psum_in    (psum1),
    .psum_out   (out_psum)
  );

endmodule

// ==== verilog/conv1_flow_ctrl.sv ====
`timescale 1ns/1ps
`include "conv1_defines.svh"

module conv1_flow_ctrl import conv1_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic fifo_empty,
  input  logic out_credit,  // receiver grants one slot
  output logic beat_en,     // pops FIFO, advances all PEs
  output logic out_valid    // result on out_psum
);

  localparam int FILL_CNT_W = $clog2(`CONV1_FILL_BEATS);

  flow_state_t           state;
  logic [FILL_CNT_W-1:0] fill_cnt;    // beats taken during fill
  credit_cnt_t           credit_cnt;  // grants not yet used
  logic                  credit_ok;   // slot left for one more result
  logic                  fill_last;   // this beat finishes fill

  // a result already on the bus still holds its credit this cycle
  assign credit_ok = credit_cnt > credit_cnt_t'(out_valid);
  assign beat_en   = !fifo_empty && (state == FILL || credit_ok);
  assign fill_last = fill_cnt == FILL_CNT_W'(`CONV1_FILL_BEATS - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= FILL;
      fill_cnt <= '0;
    end else if (beat_en && state == FILL) begin
      fill_cnt <= fill_cnt + 1'b1;
      if (fill_last) state <= RUN;  // pipeline now holds a full window
    end
  end

  // psum of PE 2 is a finished window after every run beat
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= beat_en && state == RUN;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt <= '0;
    end else begin
      case ({out_credit, out_valid})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;  // grant in
        2'b01:   credit_cnt <= credit_cnt - 1'b1;  // result out
        default: credit_cnt <= credit_cnt;         // both cancel
      endcase
    end
  end

endmodule

// ==== verilog/conv1_input_fifo.sv ====
`timescale 1ns/1ps
`include "conv1_defines.svh"

module conv1_input_fifo import conv1_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,     // sender beat, only with a credit held
  input  column_t in_column,
  input  logic    pop,          // beat enable
  output column_t fifo_column,  // head entry
  output logic    fifo_empty,
  output logic    in_credit     // one pulse per consumed beat
);

  localparam int DEPTH = `CONV1_IN_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  column_t          mem [DEPTH];  // beat storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;        // entries held
  logic             full;
  logic             push;
  logic             do_pop;

  assign full        = count == CNT_W'(DEPTH);
  assign fifo_empty  = count == '0;
  assign push        = in_valid && !full;  // credits keep sender from full
  assign do_pop      = pop && !fifo_empty;
  assign fifo_column = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_column;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither, no change
      endcase
      in_credit <= do_pop;  // credit back a cycle after the pop
    end
  end

endmodule

// ==== verilog/conv1_pe.sv ====
`timescale 1ns/1ps
`include "conv1_defines.svh"

module conv1_pe import conv1_pkg::*; #(
  parameter int SKEW = 0  // pixel delay in beats, equals depth in chain
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        beat_en,
  input  pixel_t      pixel_in,    // this row's pixel from the FIFO head
  input  weight_row_t weight_row,  // kernel row for this PE
  input  psum_t       psum_in,     // from PE above, or bias
  output psum_t       psum_out
);

  localparam int PROD_W = `CONV1_PIX_W + 1 + `CONV1_WGT_W;  // 9b x 8b signed

  pixel_t                   pixel_d;                // pixel after skew
  pixel_t                   tap [`CONV1_TAPS];      // window row
  logic signed [PROD_W-1:0] prod [`CONV1_TAPS];     // per-tap products

  // skew lines row k up with the psum that reached PE k k beats later
  if (SKEW == 0) begin : g_no_skew
    assign pixel_d = pixel_in;
  end else begin : g_skew
    pixel_t skew_q [SKEW];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        for (int i = 0; i < SKEW; i++) skew_q[i] <= '0;
      end else if (beat_en) begin
        skew_q[0] <= pixel_in;
        for (int i = 1; i < SKEW; i++) skew_q[i] <= skew_q[i-1];  // delay chain
      end
    end

    assign pixel_d = skew_q[SKEW-1];
  end

  ifmap_shift_register u_shift (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (beat_en),
    .pixel_in (pixel_d),
    .tap0     (tap[0]),
    .tap1     (tap[1]),
    .tap2     (tap[2])
  );

  for (genvar t = 0; t < `CONV1_TAPS; t++) begin : g_mult
    weight_t                     wgt;    // tap t coefficient
    logic signed [`CONV1_PIX_W:0] pix_s;  // pixel with sign bit room

    assign wgt     = weight_t'(weight_row[t*`CONV1_WGT_W +: `CONV1_WGT_W]);
    assign pix_s   = {1'b0, tap[t]};     // unsigned pixel, always positive
    assign prod[t] = pix_s * wgt;        // signed multiply
  end

  // accumulate row into incoming partial sum, hold on stalls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      psum_out <= '0;
    end else if (beat_en) begin
      psum_out <= psum_in + psum_t'(prod[0]) + psum_t'(prod[1]) + psum_t'(prod[2]);
    end
  end

endmodule

// ==== verilog/conv1_pkg.sv ====
`include "conv1_defines.svh"

package conv1_pkg;

  // one pixel of one image row
  typedef logic [`CONV1_PIX_W-1:0] pixel_t;

  // one column beat, row 0 in the low byte
  typedef logic [`CONV1_NUM_PE*`CONV1_PIX_W-1:0] column_t;

  // signed kernel coefficient
  typedef logic signed [`CONV1_WGT_W-1:0] weight_t;

  // one kernel row, tap 0 in the low byte
  typedef logic [`CONV1_TAPS*`CONV1_WGT_W-1:0] weight_row_t;

  // partial sum and result
  typedef logic signed [`CONV1_PSUM_W-1:0] psum_t;

  // config address, 0..8 weights (row*3+tap), 9 bias
  typedef logic [3:0] cfg_addr_t;

  // output credit counter, holds 0..OUT_CREDIT_MAX
  typedef logic [$clog2(`CONV1_OUT_CREDIT_MAX+1)-1:0] credit_cnt_t;

  // fill until the window pipeline holds real data, then run
  typedef enum logic {
    FILL,
    RUN
  } flow_state_t;

endpackage

// ==== verilog/conv1_weight_regs.sv ====
`timescale 1ns/1ps
`include "conv1_defines.svh"

module conv1_weight_regs import conv1_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cfg_we,       // one register per clock
  input  cfg_addr_t   cfg_addr,
  input  psum_t       cfg_wdata,    // low byte for weights, full width for bias
  output weight_row_t weight_row0,  // to PE 0
  output weight_row_t weight_row1,  // to PE 1
  output weight_row_t weight_row2,  // to PE 2
  output psum_t       bias          // psum input of PE 0
);

  localparam int        NUM_WGT   = `CONV1_NUM_PE * `CONV1_TAPS;  // nine coefficients
  localparam cfg_addr_t BIAS_ADDR = cfg_addr_t'(NUM_WGT);         // right after weights

  weight_t wgt [NUM_WGT];  // index = row*3 + tap

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_WGT; i++) wgt[i] <= '0;
      bias <= '0;
    end else if (cfg_we) begin
      if (cfg_addr < BIAS_ADDR) begin
        wgt[cfg_addr] <= weight_t'(cfg_wdata[`CONV1_WGT_W-1:0]);  // low 8 bits only
      end else if (cfg_addr == BIAS_ADDR) begin
        bias <= cfg_wdata;  // full signed bias
      end
      // addresses above 9 dropped
    end
  end

  // pack rows, tap 0 in low byte
  assign weight_row0 = {wgt[2], wgt[1], wgt[0]};
  assign weight_row1 = {wgt[5], wgt[4], wgt[3]};
  assign weight_row2 = {wgt[8], wgt[7], wgt[6]};

endmodule

// ==== verilog/ifmap_shift_register.sv ====
`timescale 1ns/1ps

module ifmap_shift_register import conv1_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   en,        // beat enable
  input  pixel_t pixel_in,  // skewed row pixel
  output pixel_t tap0,      // newest, pixel of this beat
  output pixel_t tap1,      // one beat older
  output pixel_t tap2       // two beats older
);

  // newest tap is the pixel being accepted now, so the window
  // is complete on the same beat that brings its last column
  assign tap0 = pixel_in;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tap1 <= '0;
      tap2 <= '0;
    end else if (en) begin
      tap1 <= pixel_in;  // shift in current pixel
      tap2 <= tap1;      // age out oldest
    end
  end

endmodule
